//--- main_map.f
+incdir+.
main_pkg.sv
main_bus_if.sv
main_decoder.sv
rom_banker.sv
cab_inputs.sv
prot_mul.sv
snd_video_latches.sv
main_map.sv
main_map_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the main_map testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f main_map.f --top-module main_map_tb -o main_map_sim
./obj_dir/main_map_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
grep -q "sim passed" sim.log

//--- main_map_tb.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module main_map_tb
    import main_pkg::*;
();

    logic                clk;
    logic                rst;
    logic                cpu_cen;
    logic                rnw;
    logic                vma;
    logic [`MAIN_AW-1:0] addr;
    logic [`MAIN_DW-1:0] cpu_dout;
    logic [`MAIN_DW-1:0] cpu_din;
    logic [`ROM_AW-1:0]  rom_addr;
    logic                rom_cs;
    logic [`MAIN_DW-1:0] rom_data;
    logic                rom_ok;
    logic                rom_ready;
    logic                ram_cs;
    logic [`MAIN_DW-1:0] ram_dout;
    logic                pal_cs;
    logic [`MAIN_DW-1:0] pal_dout;
    logic                gfx1_cs;
    logic                gfx2_cs;
    logic [`MAIN_DW-1:0] gfx1_dout;
    logic [`MAIN_DW-1:0] gfx2_dout;
    logic                prio_latch;
    logic [`MAIN_DW-1:0] video_bank;
    logic                snd_irq;
    logic [`MAIN_DW-1:0] snd_latch;
    logic [1:0]          start_button;
    logic [1:0]          coin_input;
    logic [5:0]          joystick1;
    logic [5:0]          joystick2;
    logic [7:0]          dipsw_a;
    logic [7:0]          dipsw_b;
    logic [3:0]          dipsw_c;

    int          errors;
    int          checks;
    int          tests;
    logic        hung;      // Set once a wait ran out
    logic [31:0] lfsr;

    main_map UUT (
        .clk, .rst, .cpu_cen, .rnw, .vma, .addr, .cpu_dout, .cpu_din,
        .rom_addr, .rom_cs, .rom_data, .rom_ok, .rom_ready,
        .ram_cs, .ram_dout, .pal_cs, .pal_dout,
        .gfx1_cs, .gfx2_cs, .gfx1_dout, .gfx2_dout,
        .prio_latch, .video_bank, .snd_irq, .snd_latch,
        .start_button, .coin_input, .joystick1, .joystick2,
        .dipsw_a, .dipsw_b, .dipsw_c
    );

    always #20 clk = ~clk;     // 40 ns period

    // Galois LFSR, one step per bit taken, newest bit lands in the LSB
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // External data per region, 4 is open bus
    function automatic logic [7:0] src_byte(input int region);
        case (region)
            0: return 8'hA5;    // ROM
            1: return 8'h3C;    // RAM
            2: return 8'h5A;    // Palette
            3: return 8'h96;    // Tile chip 1
            5: return 8'h69;    // Tile chip 2
            default: return 8'hFF;
        endcase
    endfunction

    // Step to the next falling clk, polled in 1 ns steps
    task automatic next_fall(input string what);
        int   guard;
        logic was_high;
        logic fell;
        guard = 0;
        fell = 1'b0;
        while (!fell && !hung) begin
            was_high = clk;
            #1;
            guard++;
            fell = was_high && !clk;
            if (!fell && guard >= 100) begin
                $display("Timeout: no falling clk edge within 100 ns during %s", what);
                hung = 1'b1;
            end
        end
    endtask

    // One cen cycle each, outputs sampled at the following falling edge
    task automatic cpu_read(input logic [15:0] a, input logic v);
        addr = a;
        rnw = 1'b1;
        vma = v;
        cpu_cen = 1'b1;
        cpu_dout = 8'h00;
        next_fall("read");
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        addr = a;
        rnw = 1'b0;
        vma = 1'b1;
        cpu_cen = 1'b1;
        cpu_dout = d;
        next_fall("write");
    endtask

    task automatic idle_cycle();
        cpu_cen = 1'b0;     // CPU stalled
        rnw = 1'b1;
        vma = 1'b0;
        next_fall("idle");
    endtask

    task automatic check_byte(input string name, input logic [`MAIN_DW-1:0] got,
                              input logic [`MAIN_DW-1:0] exp);
        if (!hung) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (!hung) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            end
        end
    endtask

    task automatic check_addr(input string name, input logic [`ROM_AW-1:0] got,
                              input logic [`ROM_AW-1:0] exp);
        if (!hung) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            end
        end
    endtask

    task automatic check_prot(input string name, input prot_result_u got,
                              input prot_result_u exp);
        if (!hung) begin
            checks++;
            if (got.word !== exp.word) begin
                errors++;
                $display("MISMATCH at %0t: %s got %h expected %h",
                         $time, name, got.word, exp.word);
            end
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        tests++;
        if (errors == err_at_start)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_at_start);
    endtask

    task automatic reset_state();
        int e0;
        e0 = errors;
        check_byte("video_bank", video_bank, 8'h00);
        check_byte("snd_latch", snd_latch, 8'h00);
        check_bit("prio_latch", prio_latch, 1'b0);
        check_bit("snd_irq", snd_irq, 1'b0);
        check_bit("rom_ready", rom_ready, 1'b1);
        rom_ok = 1'b0;                         // ROM busy for one cycle
        cpu_read(16'h2000, 1'b1);
        check_bit("gfx1_cs", gfx1_cs, 1'b1);   // Tile chip 1 after reset
        check_bit("gfx2_cs", gfx2_cs, 1'b0);
        check_bit("rom_ready", rom_ready, 1'b0);
        rom_ok = 1'b1;
        end_test("reset", e0);
    endtask

    task automatic region_decode();
        logic [15:0] sample [9];
        int          region [9];
        int          e0;
        sample = '{16'h4123, 16'hC000, 16'h0800, 16'h1FFF, 16'h0640,
                   16'h2800, 16'h01F0, 16'h0420, 16'h041C};
        region = '{0, 0, 1, 1, 2, 3, 3, 4, 4};
        e0 = errors;
        for (int i = 0; i < 9; i++) begin
            cpu_read(sample[i], 1'b1);
            check_bit("rom_cs", rom_cs, region[i] == 0);
            check_bit("ram_cs", ram_cs, region[i] == 1);
            check_bit("pal_cs", pal_cs, region[i] == 2);
            check_bit("gfx1_cs", gfx1_cs, region[i] == 3);
            check_bit("gfx2_cs", gfx2_cs, 1'b0);
            check_byte("cpu_din", cpu_din, src_byte(region[i]));
        end
        cpu_read(16'hC000, 1'b0);     // No valid access, ROM stays off
        check_bit("rom_cs", rom_cs, 1'b0);
        check_byte("cpu_din", cpu_din, 8'hFF);
        end_test("regions", e0);
    endtask

    task automatic rom_banking();
        logic [7:0]  b;
        logic [15:0] a;
        logic [17:0] exp;
        int          e0;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            b = 8'(rand_bits(8));
            b[4] = k[0];          // Alternate window modes
            b[6] = k[1];          // Both tile chips
            cpu_write(16'h0410, b);
            for (int j = 0; j < 3; j++) begin
                a = 16'h4000 | 16'(rand_bits(14));
                cpu_read(a, 1'b1);
                if (b[4])
                    exp = 18'h1_0000 + 18'(b[3:1]) * 18'h4000 + 18'(a[13:0]);
                else
                    exp = 18'(b[0]) * 18'h4000 + 18'(a[13:0]);
                check_addr("rom_addr", rom_addr, exp);
            end
            a = 16'h8000 | 16'(rand_bits(15));
            cpu_read(a, 1'b1);
            check_addr("rom_addr", rom_addr, 18'(a));   // Fixed area unchanged
            cpu_read(16'h2000, 1'b1);
            check_bit("gfx2_cs", gfx2_cs, b[6]);
            check_bit("gfx1_cs", gfx1_cs, !b[6]);
            check_byte("cpu_din", cpu_din, b[6] ? src_byte(5) : src_byte(3));
            check_bit("prio_latch", prio_latch, b[5]);
        end
        end_test("banking", e0);
    endtask

    task automatic cabinet_ports();
        logic [7:0] exp;
        int         e0;
        e0 = errors;
        start_button = 2'(rand_bits(2));
        coin_input = 2'(rand_bits(2));
        joystick1 = 6'(rand_bits(6));
        joystick2 = 6'(rand_bits(6));
        dipsw_a = 8'(rand_bits(8));
        dipsw_b = 8'(rand_bits(8));
        dipsw_c = 4'(rand_bits(4));
        for (int c = 0; c < 8; c++) begin
            cpu_read(16'h0400 | 16'(c), 1'b1);    // Registered one clk in
            exp = 8'hFF;                          // Unwired bits idle high
            case (c)
                0: begin                          // Player 1 port
                    exp[1:0] = joystick1[5:4];
                    exp[2]   = start_button[0];
                    exp[4:3] = coin_input;
                end
                1: begin                          // Player 2 port with DIP bank C
                    exp[1:0] = joystick2[5:4];
                    exp[2]   = start_button[1];
                    exp[7:4] = dipsw_c;
                end
                2: exp = dipsw_a;
                3: exp = dipsw_b;
                4: begin                          // Directions
                    exp[3:0] = joystick2[3:0];
                    exp[7:4] = joystick1[3:0];
                end
                default: ;
            endcase
            check_byte("cpu_din", cpu_din, exp);
        end
        end_test("cabinet", e0);
    endtask

    task automatic prot_multiply();
        logic [7:0]   f0;
        logic [7:0]   f1;
        prot_result_u got;
        prot_result_u exp;
        int           e0;
        e0 = errors;
        for (int k = 0; k < 3; k++) begin
            f0 = 8'(rand_bits(8));
            f1 = 8'(rand_bits(8));
            cpu_write(16'h0200, f0);
            cpu_write(16'h0201, f1);
            idle_cycle();                 // Product register catches up
            cpu_read(16'h0200, 1'b1);
            got.bytes[0] = cpu_din;
            cpu_read(16'h0201, 1'b1);
            got.bytes[1] = cpu_din;
            exp.word = 16'(f0) * 16'(f1);
            check_prot("prot", got, exp);
        end
        end_test("protection", e0);
    endtask

    task automatic sound_video();
        logic [7:0] v;
        logic [7:0] s;
        int         e0;
        e0 = errors;
        v = 8'(rand_bits(8));
        cpu_write(16'h040C, v);
        check_byte("video_bank", video_bank, v);
        s = 8'(rand_bits(8));
        cpu_write(16'h0414, s);
        check_byte("snd_latch", snd_latch, s);
        check_bit("snd_irq", snd_irq, 1'b0);
        cpu_read(16'h0418, 1'b1);
        check_bit("snd_irq", snd_irq, 1'b1);
        idle_cycle();                     // Held while cen stays low
        check_bit("snd_irq", snd_irq, 1'b1);
        cpu_read(16'h0900, 1'b1);
        check_bit("snd_irq", snd_irq, 1'b0);
        end_test("latches", e0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests = 0;
        hung = 1'b0;
        lfsr = 32'hb118;
        clk = 1'b0;
        rst = 1'b1;
        cpu_cen = 1'b0;
        rnw = 1'b1;
        vma = 1'b0;
        addr = '0;
        cpu_dout = '0;
        rom_data = src_byte(0);
        ram_dout = src_byte(1);
        pal_dout = src_byte(2);
        gfx1_dout = src_byte(3);
        gfx2_dout = src_byte(5);
        rom_ok = 1'b1;
        start_button = '0;
        coin_input = '0;
        joystick1 = '0;
        joystick2 = '0;
        dipsw_a = '0;
        dipsw_b = '0;
        dipsw_c = '0;
        next_fall("reset");
        next_fall("reset");
        rst = 1'b0;                       // Two rising edges in reset
        reset_state();
        region_decode();
        rom_banking();
        cabinet_ports();
        prot_multiply();
        sound_video();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !hung) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- main_map.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module main_map
    import main_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cen,
    input  logic                rnw,
    input  logic                vma,
    input  logic [`MAIN_AW-1:0] addr,
    input  logic [`MAIN_DW-1:0] cpu_dout,
    output logic [`MAIN_DW-1:0] cpu_din,
    // ROM
    output logic [`ROM_AW-1:0]  rom_addr,
    output logic                rom_cs,
    input  logic [`MAIN_DW-1:0] rom_data,
    input  logic                rom_ok,
    output logic                rom_ready,      // rom_ok handed on to the CPU clocking
    // RAM, palette and tile chips
    output logic                ram_cs,
    input  logic [`MAIN_DW-1:0] ram_dout,
    output logic                pal_cs,
    input  logic [`MAIN_DW-1:0] pal_dout,
    output logic                gfx1_cs,
    output logic                gfx2_cs,
    input  logic [`MAIN_DW-1:0] gfx1_dout,
    input  logic [`MAIN_DW-1:0] gfx2_dout,
    // Latches
    output logic                prio_latch,
    output logic [`MAIN_DW-1:0] video_bank,
    output logic                snd_irq,
    output logic [`MAIN_DW-1:0] snd_latch,
    // Cabinet
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [5:0]          joystick1,
    input  logic [5:0]          joystick2,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    input  logic [3:0]          dipsw_c
);

    main_bus_if bus ();

    logic                video_sel;
    logic [`MAIN_DW-1:0] port_byte;
    prot_result_u        prot;

    assign bus.addr   = addr;
    assign bus.rnw    = rnw;
    assign bus.vma    = vma;
    assign bus.cen    = cpu_cen;
    assign bus.wdata  = cpu_dout;
    assign rom_ready  = rom_ok;

    main_decoder u_dec (
        .bus(bus.dec), .video_sel, .port_byte, .prot,
        .rom_data, .ram_dout, .pal_dout, .gfx1_dout, .gfx2_dout,
        .rom_cs, .ram_cs, .pal_cs, .gfx1_cs, .gfx2_cs, .cpu_din
    );

    rom_banker u_bank (
        .clk, .rst, .bus(bus.periph), .rom_addr, .video_sel, .prio_latch
    );

    cab_inputs u_cab (
        .clk, .addr_lo(addr[2:0]), .start_button, .coin_input,
        .joystick1, .joystick2, .dipsw_a, .dipsw_b, .dipsw_c, .port_byte
    );

    prot_mul u_prot (
        .clk, .rst, .bus(bus.periph), .prot
    );

    snd_video_latches u_latch (
        .clk, .rst, .bus(bus.periph), .snd_latch, .video_bank, .snd_irq
    );

endmodule

//--- snd_video_latches.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module snd_video_latches (
    input  logic                clk,
    input  logic                rst,
    main_bus_if.periph          bus,
    output logic [`MAIN_DW-1:0] snd_latch,     // Command for the sound CPU
    output logic [`MAIN_DW-1:0] video_bank,
    output logic                snd_irq         // One cen cycle wide
);

    logic wr_cyc;   // Write strobe, CPU cycle qualified

    assign wr_cyc = bus.cen && !bus.rnw;

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_latch  <= '0;
            video_bank <= '0;
            snd_irq    <= 1'b0;
        end else begin
            if (bus.cen)
                snd_irq <= bus.son_sel;  // Any access here fires it, read or write
            if (wr_cyc && bus.sdata_sel)
                snd_latch <= bus.wdata;
            if (wr_cyc && bus.vbank_sel)
                video_bank <= bus.wdata;
        end
    end

endmodule

//--- prot_mul.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module prot_mul
    import main_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    main_bus_if.periph  bus,
    output prot_result_u prot
);

    logic [`MAIN_DW-1:0] fac [2];   // Factor 0 at A0 low, factor 1 at A0 high
    logic                fac_we;

    // Writes only at 0200/0201 and their mirrors, no cen qualifier
    assign fac_we = bus.prot_sel && bus.addr[2:1] == 2'b00 && !bus.rnw;

    always_ff @(posedge clk) begin
        if (rst) begin
            fac[0]    <= '0;
            fac[1]    <= '0;
            prot.word <= '0;
        end else begin
            prot.word <= {{`MAIN_DW{1'b0}}, fac[0]} * {{`MAIN_DW{1'b0}}, fac[1]};  // Every clk
            if (fac_we)
                fac[bus.addr[0]] <= bus.wdata;
        end
    end

endmodule

//--- cab_inputs.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module cab_inputs (
    input  logic                clk,
    input  logic [2:0]          addr_lo,        // A2-A0 of the input page
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [5:0]          joystick1,      // 5:4 buttons, 3:0 directions
    input  logic [5:0]          joystick2,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    input  logic [3:0]          dipsw_c,
    output logic [`MAIN_DW-1:0] port_byte
);

    // One register stage, the CPU samples a cycle later
    always_ff @(posedge clk) begin
        case (addr_lo)
            3'd0: port_byte <= {3'b111, coin_input, start_button[0], joystick1[5:4]};
            3'd1: port_byte <= {dipsw_c, 1'b1, start_button[1], joystick2[5:4]};
            3'd2: port_byte <= dipsw_a;
            3'd3: port_byte <= dipsw_b;
            3'd4: port_byte <= {joystick1[3:0], joystick2[3:0]};   // Directions only
            default: port_byte <= '1;                              // Nothing wired
        endcase
    end

endmodule

//--- rom_banker.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module rom_banker (
    input  logic              clk,
    input  logic              rst,
    main_bus_if.periph        bus,
    output logic [`ROM_AW-1:0] rom_addr,
    output logic              video_sel,    // Picks tile chip 2
    output logic              prio_latch    // Layer priority
);

    logic       bank_en;    // Wide banking through the upper ROM half
    logic [3:0] bank;

    // Bank register, bit layout 6 video sel, 5 prio, 4 enable, 3:0 bank
    always_ff @(posedge clk) begin
        if (rst) begin
            video_sel  <= 1'b0;
            prio_latch <= 1'b0;
            bank_en    <= 1'b0;
            bank       <= 4'd0;
        end else if (bus.cen && bus.bank_sel && !bus.rnw) begin
            video_sel  <= bus.wdata[6];
            prio_latch <= bus.wdata[5];
            bank_en    <= bus.wdata[4];
            bank       <= bus.wdata[3:0];
        end
    end

    // CPU window 4000-7FFF is the banked one
    always_comb begin
        if (bus.addr[15:14] == 2'b01) begin
            if (bank_en)
                rom_addr = `ROM_BANK_BASE + {1'b0, bank[3:1], bus.addr[13:0]};
            else
                rom_addr = {3'b000, bank[0], bus.addr[13:0]};  // Low 64 KiB
        end else begin
            rom_addr = {{(`ROM_AW - `MAIN_AW){1'b0}}, bus.addr};  // Fixed area
        end
    end

endmodule

//--- main_decoder.sv
`timescale 1ns/10ps

`include "main_consts.svh"

module main_decoder
    import main_pkg::*;
(
    main_bus_if.dec             bus,
    input  logic                video_sel,  // Tile chip steering from bank reg
    input  logic [`MAIN_DW-1:0] port_byte,
    input  prot_result_u        prot,
    input  logic [`MAIN_DW-1:0] rom_data,
    input  logic [`MAIN_DW-1:0] ram_dout,
    input  logic [`MAIN_DW-1:0] pal_dout,
    input  logic [`MAIN_DW-1:0] gfx1_dout,
    input  logic [`MAIN_DW-1:0] gfx2_dout,
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                pal_cs,
    output logic                gfx1_cs,
    output logic                gfx2_cs,
    output logic [`MAIN_DW-1:0] cpu_din
);

    logic       io_sel;     // 0400-041F
    logic       gfx_sel;    // Either tile chip
    logic [2:0] io_sub;     // Second-level I/O code

    assign io_sub = bus.addr[4:2];

    // First level looks at A15-A9 only
    always_comb begin
        rom_cs  = (bus.addr[15] || bus.addr[15:14] == 2'b01) && bus.vma;   // 4000-FFFF
        ram_cs  = bus.addr[15:12] == 4'b0001 ||
                  bus.addr[15:11] == 5'b0000_1;                        // 0800-1FFF
        io_sel  = bus.addr[15:9] == 7'h02 && !bus.addr[5];
        pal_cs  = bus.addr[15:9] == 7'h03;                             // 0600-07FF
        gfx_sel = bus.addr[15:13] == 3'b001 ||
                  bus.addr[15:9] == 7'h00;                             // 2000-3FFF, 0000-01FF
        gfx1_cs = gfx_sel && !video_sel;
        gfx2_cs = gfx_sel && video_sel;
        bus.prot_sel = bus.addr[15:9] == 7'h01;                        // 0200-03FF
    end

    // I/O page, split on A4-A2
    always_comb begin
        bus.in_sel    = io_sel && (io_sub < `IO_COIN);    // 0400-0407
        bus.vbank_sel = io_sel && io_sub == `IO_VBANK;
        bus.bank_sel  = io_sel && io_sub == `IO_BANK;
        bus.sdata_sel = io_sel && io_sub == `IO_SOUND_DATA;
        bus.son_sel   = io_sel && io_sub == `IO_SOUND_ON;
    end

    // Read mux, first hit wins
    // cpu_din follows addr in the same CPU cycle
    always_comb begin
        case (1'b1)
            rom_cs:       cpu_din = rom_data;
            ram_cs:       cpu_din = ram_dout;
            pal_cs:       cpu_din = pal_dout;
            bus.in_sel:   cpu_din = port_byte;
            bus.prot_sel: cpu_din = prot.bytes[bus.addr[0]];  // A0 high reads MSB
            gfx1_cs:      cpu_din = gfx1_dout;
            gfx2_cs:      cpu_din = gfx2_dout;
            default:      cpu_din = '1;                       // Open bus
        endcase
    end

endmodule

//--- main_bus_if.sv
`timescale 1ns/10ps

`include "main_consts.svh"

interface main_bus_if;
    logic [`MAIN_AW-1:0] addr;
    logic                rnw;       // High on reads
    logic                vma;       // Valid memory access
    logic                cen;       // CPU clock enable
    logic [`MAIN_DW-1:0] wdata;     // CPU write data

    // Decoded selects
    logic in_sel;       // Cabinet input page
    logic bank_sel;     // ROM bank register
    logic vbank_sel;    // Video bank latch
    logic sdata_sel;    // Sound command
    logic son_sel;      // Sound interrupt trigger
    logic prot_sel;     // Protection multiplier

    modport dec (
        input  addr, rnw, vma, cen, wdata,
        output in_sel, bank_sel, vbank_sel, sdata_sel, son_sel, prot_sel
    );

    modport periph (
        input addr, rnw, vma, cen, wdata,
        input in_sel, bank_sel, vbank_sel, sdata_sel, son_sel, prot_sel
    );
endinterface

//--- main_pkg.sv
package main_pkg;

`include "main_consts.svh"

    // Protection multiplier result
    // Written as one product word, read back one byte at a time
    typedef union packed {
        logic [2*`MAIN_DW-1:0]      word;   // Full 8x8 product
        logic [1:0][`MAIN_DW-1:0]   bytes;  // bytes[0] is the low half, A0 picks
    } prot_result_u;

endpackage

//--- main_consts.svh
`ifndef MAIN_CONSTS_SVH
`define MAIN_CONSTS_SVH

// CPU bus widths
`define MAIN_AW 16
`define MAIN_DW 8

// Banked ROM space, 256 KiB
`define ROM_AW  18

// Upper bank window starts 64 KiB into the ROM
`define ROM_BANK_BASE 18'h1_0000

// I/O page sub-selects, address bits 4 to 2
`define IO_COIN       3'd2   // 0408, coin counters; input page sits below it
`define IO_VBANK      3'd3   // 040C
`define IO_BANK       3'd4   // 0410
`define IO_SOUND_DATA 3'd5   // 0414
`define IO_SOUND_ON   3'd6   // 0418

`endif
